// File: verilog.f
slideshow_pkg.sv
pixel_writer.sv
mem_arbiter.sv
frame_mem.sv
raster_reader.sv
swipe_debounce.sv
image_select.sv
slideshow_top.sv
tb_slideshow.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_slideshow -f verilog.f -o tb_slideshow \
	&& ./obj_dir/tb_slideshow | tee /dev/stderr | grep -q "sim passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: tb_slideshow.sv
// Slideshow controller testbench
// Streams three random images into the frame memory, then walks a table
// of swipes and frame waits. A display monitor checks de, the syncs and
// every visible pixel against a model of the loaded images

module tb_slideshow;

	timeunit 1ns;
	timeprecision 100ps;

	import slideshow_pkg::*;

	localparam int H_ACTIVE       = 16;
	localparam int H_TOTAL        = 20;
	localparam int V_ACTIVE       = 8;
	localparam int V_TOTAL        = 10;
	localparam int PIXELS_PER_IMG = 128;
	localparam int LOAD_SETTLE    = 50;
	localparam int SWIPE_DELAY    = 20;
	localparam int SWIPE_LOCKOUT  = 60;
	localparam int NUM_ROWS       = 8;
	// One scan position every two cycles
	localparam int FRAME_CYC      = H_TOTAL * V_TOTAL * 2;
	// Worst case strobe spacing of three cycles
	localparam int LOAD_CYC       = 4 * PIXELS_PER_IMG * 3 + LOAD_SETTLE;
	localparam int LIMIT          = NUM_ROWS * FRAME_CYC * 2 + LOAD_CYC + 2000;

	typedef enum logic [1:0] {
		OP_LOAD,
		OP_EAST,
		OP_WEST,
		OP_WAIT
	} op_t;

	// num is the image count for a load, the frame count for a wait
	// gap spaces a second trigger of a swipe, 0 for a single one
	typedef struct packed {
		op_t       op;
		logic [7:0] num;
		logic [7:0] gap;
		img_idx_t   exp;
	} row_t;

	row_t rows [0:NUM_ROWS-1] = '{
		'{OP_LOAD, 8'd3, 8'd0,  2'd0},
		'{OP_WAIT, 8'd1, 8'd0,  2'd0},
		// Wraps from 0 to the last image
		'{OP_EAST, 8'd0, 8'd0,  2'd2},
		// Wraps from the last image to 0
		'{OP_WEST, 8'd0, 8'd0,  2'd0},
		'{OP_WEST, 8'd0, 8'd0,  2'd1},
		// Second trigger inside the lockout
		'{OP_EAST, 8'd0, 8'd30, 2'd0},
		// Second trigger after the lockout, two steps
		'{OP_EAST, 8'd0, 8'd70, 2'd1},
		'{OP_WAIT, 8'd2, 8'd0,  2'd1}
	};

	logic     CLOCK_33 = 1'b0;
	logic     iRSTN;
	logic     pixel_stb;
	pixel_t   pixel_in;
	logic [2:0] img_num;
	logic     touch_ready;
	gesture_t gesture;
	pixel_t   rgb;
	logic     de;
	logic     hsync_n;
	logic     vsync_n;
	logic     loading;
	img_idx_t shown_img;

	// Loaded images, back to back as in the frame memory
	pixel_t   model [0:4*PIXELS_PER_IMG-1];

	int       errors     = 0;
	int       checks     = 0;
	int       pix_checks = 0;
	int       cycles     = 0;
	// Monitor state
	logic     check_en   = 1'b0;
	logic     armed      = 1'b0;
	logic     prev_vs    = 1'b1;
	int       pos        = 0;
	int       frame_cnt  = 0;
	img_idx_t frame_img  = '0;
	// Image expected from the next frame start on
	img_idx_t exp_img    = '0;

	slideshow_top #(
		.H_ACTIVE       (H_ACTIVE),
		.H_TOTAL        (H_TOTAL),
		.V_ACTIVE       (V_ACTIVE),
		.V_TOTAL        (V_TOTAL),
		.PIXELS_PER_IMG (PIXELS_PER_IMG),
		.LOAD_SETTLE    (LOAD_SETTLE),
		.SWIPE_DELAY    (SWIPE_DELAY),
		.SWIPE_LOCKOUT  (SWIPE_LOCKOUT)
	) dut (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.pixel_stb   (pixel_stb),
		.pixel_in    (pixel_in),
		.img_num     (img_num),
		.touch_ready (touch_ready),
		.gesture     (gesture),
		.rgb         (rgb),
		.de          (de),
		.hsync_n     (hsync_n),
		.vsync_n     (vsync_n),
		.loading     (loading),
		.shown_img   (shown_img)
	);

	always #5 CLOCK_33 = ~CLOCK_33;

	// ==============================
	// Helpers
	// ==============================
	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// One-cycle touch report
	task automatic send_gesture(input gesture_t code);
		touch_ready = 1'b1;
		gesture     = code;
		@(negedge CLOCK_33);
		touch_ready = 1'b0;
		gesture     = '0;
	endtask

	// Returns one cycle after the monitor sees vsync_n rise
	task automatic wait_frame_start();
		int start;
		start = frame_cnt;
		while (frame_cnt == start) begin
			@(negedge CLOCK_33);
		end
	endtask

	task automatic load_images(input int n);
		int gap;
		img_num = 3'(n);
		for (int i = 0; i < n * PIXELS_PER_IMG; i++) begin
			model[i]  = 24'($urandom);
			pixel_stb = 1'b1;
			pixel_in  = model[i];
			// Swipe during the load must be ignored
			if (i == 10) begin
				touch_ready = 1'b1;
				gesture     = GEST_WEST;
			end
			@(negedge CLOCK_33);
			pixel_stb   = 1'b0;
			touch_ready = 1'b0;
			gesture     = '0;
			if (i == 0) begin
				check_equal("loading", loading, 1'b1);
			end
			gap = $urandom_range(3, 2);
			repeat (gap - 1) @(negedge CLOCK_33);
		end
		// Still settling shortly before the settle time
		repeat (LOAD_SETTLE - 5) @(negedge CLOCK_33);
		check_equal("loading", loading, 1'b1);
		repeat (10) @(negedge CLOCK_33);
		check_equal("loading", loading, 1'b0);
		check_en <= 1'b1;
	endtask

	// Swipe early in a frame, old image kept until the frame ends
	task automatic run_swipe(input gesture_t code, input int gap, input img_idx_t old,
			input img_idx_t new_img);
		wait_frame_start();
		send_gesture(code);
		if (gap != 0) begin
			repeat (gap - 1) @(negedge CLOCK_33);
			send_gesture(code);
		end
		repeat (SWIPE_DELAY + 10) @(negedge CLOCK_33);
		check_equal("shown_img", shown_img, old);
		// Monitor expects the new image from the next frame on
		exp_img <= new_img;
		wait_frame_start();
	endtask

	// ==============================
	// Display monitor
	// ==============================
	always @(negedge CLOCK_33) begin : display_monitor
		int       cur;
		int       px;
		int       py;
		logic     arm;
		logic     vis;
		img_idx_t img;
		if (vsync_n === 1'b1 && prev_vs === 1'b0) begin
			// Position 0,0 of a new frame
			cur       = 0;
			img       = exp_img;
			arm       = check_en;
			frame_cnt <= frame_cnt + 1;
		end else begin
			cur = pos;
			img = frame_img;
			arm = armed;
		end
		prev_vs   <= vsync_n;
		pos       <= cur + 1;
		frame_img <= img;
		armed     <= arm;
		if (arm) begin
			px  = (cur / 2) % H_TOTAL;
			py  = (cur / 2) / H_TOTAL;
			vis = (px < H_ACTIVE) && (py < V_ACTIVE);
			check_equal("de", de, vis);
			check_equal("hsync_n", hsync_n, px != H_TOTAL - 1);
			check_equal("vsync_n", vsync_n, py != V_TOTAL - 1);
			if (vis) begin
				check_equal("rgb", rgb,
					model[int'(img) * PIXELS_PER_IMG + py * H_ACTIVE + px]);
				check_equal("shown_img", shown_img, img);
				pix_checks++;
			end
		end
	end

	// ==============================
	// Timeout
	// ==============================
	always @(posedge CLOCK_33) begin
		cycles++;
		if (cycles == LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("checks %0d errors %0d", checks, errors);
			$display("sim failed");
			$finish;
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin : stimulus
		img_idx_t prev_exp;
		void'($urandom(32'hebca0cbb));
		iRSTN       = 1'b0;
		pixel_stb   = 1'b0;
		pixel_in    = '0;
		img_num     = 3'd0;
		touch_ready = 1'b0;
		gesture     = '0;
		repeat (2) @(posedge CLOCK_33);
		@(negedge CLOCK_33);
		iRSTN = 1'b1;
		@(negedge CLOCK_33);
		// Reset state
		check_equal("de", de, 1'b0);
		check_equal("hsync_n", hsync_n, 1'b1);
		check_equal("vsync_n", vsync_n, 1'b1);
		check_equal("loading", loading, 1'b0);
		check_equal("shown_img", shown_img, 2'd0);
		prev_exp = '0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			case (rows[r].op)
				OP_LOAD: load_images(int'(rows[r].num));
				OP_WAIT: repeat (int'(rows[r].num)) wait_frame_start();
				OP_EAST: run_swipe(GEST_EAST, int'(rows[r].gap), prev_exp, rows[r].exp);
				default: run_swipe(GEST_WEST, int'(rows[r].gap), prev_exp, rows[r].exp);
			endcase
			check_equal("shown_img", shown_img, rows[r].exp);
			prev_exp = rows[r].exp;
		end
		// Let the last frame be checked in full
		wait_frame_start();
		if (pix_checks == 0) begin
			errors++;
			$display("No displayed pixel was ever checked");
		end
		$display("checks %0d pixels %0d errors %0d", checks, pix_checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: slideshow_top.sv
// Slideshow frame-buffer controller
// Pixel writer and raster reader share one frame memory through a
// time-slot arbiter. Two debounced swipe detectors drive the image
// selection, which feeds the reader its base address per frame

module slideshow_top #(
	parameter int H_ACTIVE       = 16,
	parameter int H_TOTAL        = 20,
	parameter int V_ACTIVE       = 8,
	parameter int V_TOTAL        = 10,
	parameter int PIXELS_PER_IMG = 128,
	parameter int LOAD_SETTLE    = 50,
	parameter int SWIPE_DELAY    = 20,
	parameter int SWIPE_LOCKOUT  = 60
) (
	input  logic                    CLOCK_33,
	input  logic                    iRSTN,
	input  logic                    pixel_stb,
	input  slideshow_pkg::pixel_t   pixel_in,
	input  logic [2:0]              img_num,
	input  logic                    touch_ready,
	input  slideshow_pkg::gesture_t gesture,
	output slideshow_pkg::pixel_t   rgb,
	output logic                    de,
	output logic                    hsync_n,
	output logic                    vsync_n,
	output logic                    loading,
	output slideshow_pkg::img_idx_t shown_img
);

	import slideshow_pkg::*;

	// Memory side
	mem_req_t  wr_req;
	mem_req_t  rd_req;
	mem_req_t  mem_req;
	logic      mem_we;
	logic      wr_slot;
	logic      rd_slot;
	pixel_t    rd_data;

	// Control
	logic      load_done;
	logic      frame_end;
	logic      swipe_east;
	logic      swipe_west;
	mem_addr_t base_addr;

	// ==============================
	// Memory path
	// ==============================
	pixel_writer #(
		.PIXELS_PER_IMG (PIXELS_PER_IMG),
		.LOAD_SETTLE    (LOAD_SETTLE)
	) u_writer (
		.CLOCK_33  (CLOCK_33),
		.iRSTN     (iRSTN),
		.pixel_stb (pixel_stb),
		.pixel_in  (pixel_in),
		.img_num   (img_num),
		.wr_slot   (wr_slot),
		.wr_req    (wr_req),
		.load_done (load_done),
		.loading   (loading)
	);

	mem_arbiter u_arbiter (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.wr_req   (wr_req),
		.rd_req   (rd_req),
		.wr_slot  (wr_slot),
		.rd_slot  (rd_slot),
		.mem_req  (mem_req),
		.mem_we   (mem_we)
	);

	frame_mem u_mem (
		.CLOCK_33 (CLOCK_33),
		.mem_req  (mem_req),
		.mem_we   (mem_we),
		.rd_data  (rd_data)
	);

	raster_reader #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) u_reader (
		.CLOCK_33  (CLOCK_33),
		.iRSTN     (iRSTN),
		.rd_slot   (rd_slot),
		.base_addr (base_addr),
		.rd_data   (rd_data),
		.rd_req    (rd_req),
		.frame_end (frame_end),
		.rgb       (rgb),
		.de        (de),
		.hsync_n   (hsync_n),
		.vsync_n   (vsync_n)
	);

	// ==============================
	// Touch and selection
	// ==============================

	// East steps backwards
	swipe_debounce #(
		.GESTURE_CODE  (GEST_EAST),
		.SWIPE_DELAY   (SWIPE_DELAY),
		.SWIPE_LOCKOUT (SWIPE_LOCKOUT)
	) u_swipe_east (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.touch_ready (touch_ready),
		.gesture     (gesture),
		.swipe       (swipe_east)
	);

	// West steps forwards
	swipe_debounce #(
		.GESTURE_CODE  (GEST_WEST),
		.SWIPE_DELAY   (SWIPE_DELAY),
		.SWIPE_LOCKOUT (SWIPE_LOCKOUT)
	) u_swipe_west (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.touch_ready (touch_ready),
		.gesture     (gesture),
		.swipe       (swipe_west)
	);

	image_select #(
		.PIXELS_PER_IMG (PIXELS_PER_IMG)
	) u_select (
		.CLOCK_33   (CLOCK_33),
		.iRSTN      (iRSTN),
		.load_done  (load_done),
		.img_num    (img_num),
		.swipe_east (swipe_east),
		.swipe_west (swipe_west),
		.frame_end  (frame_end),
		.base_addr  (base_addr),
		.shown_img  (shown_img)
	);

endmodule

// File: image_select.sv
// Image select
// Steps the current image on east and west swipes, with wrap-around,
// once all images are loaded. At each frame end the current image
// becomes the shown image and its base address is latched for the
// reader, so a change never shows in the middle of a frame

module image_select #(
	parameter int PIXELS_PER_IMG = 128
) (
	input  logic                     CLOCK_33,
	input  logic                     iRSTN,
	input  logic                     load_done,
	input  logic [2:0]               img_num,
	input  logic                     swipe_east,
	input  logic                     swipe_west,
	input  logic                     frame_end,
	output slideshow_pkg::mem_addr_t base_addr,
	output slideshow_pkg::img_idx_t  shown_img
);

	import slideshow_pkg::*;

	img_idx_t cur_img;
	// Highest valid index
	img_idx_t last_img;

	assign last_img = img_idx_t'(img_num - 3'd1);

	// ==============================
	// Current image
	// ==============================
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			cur_img <= '0;
		end else if (load_done) begin
			if (swipe_east) begin
				// Backwards
				if (cur_img == '0) begin
					cur_img <= last_img;
				end else begin
					cur_img <= cur_img - 1'b1;
				end
			end else if (swipe_west) begin
				// Forwards
				if (cur_img == last_img) begin
					cur_img <= '0;
				end else begin
					cur_img <= cur_img + 1'b1;
				end
			end
		end
	end

	// Per-frame latch of the displayed image
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			shown_img <= '0;
			base_addr <= '0;
		end else if (frame_end) begin
			shown_img <= cur_img;
			base_addr <= mem_addr_t'(cur_img) * mem_addr_t'(PIXELS_PER_IMG);
		end
	end

endmodule

// File: swipe_debounce.sv
// Swipe debounce
// Matches one gesture code on the touch ready strobe, waits a delay,
// then emits a one-cycle swipe pulse. Further triggers are locked
// out until the lockout time has passed since the first one

module swipe_debounce #(
	parameter slideshow_pkg::gesture_t GESTURE_CODE  = slideshow_pkg::GEST_EAST,
	parameter int                      SWIPE_DELAY   = 20,
	parameter int                      SWIPE_LOCKOUT = 60
) (
	input  logic                    CLOCK_33,
	input  logic                    iRSTN,
	input  logic                    touch_ready,
	input  slideshow_pkg::gesture_t gesture,
	output logic                    swipe
);

	localparam int CNT_W = $clog2(SWIPE_LOCKOUT + 1);

	logic             trigger;
	logic             active;
	// Cycles since the accepted trigger
	logic [CNT_W-1:0] count;

	// Our gesture only
	assign trigger = touch_ready && (gesture == GESTURE_CODE);

	// ==============================
	// Delay and lockout counter
	// ==============================
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			active <= 1'b0;
			count  <= '0;
		end else if (!active) begin
			if (trigger) begin
				active <= 1'b1;
				count  <= CNT_W'(1);
			end
		end else if (count == CNT_W'(SWIPE_LOCKOUT - 1)) begin
			// Ready again on the next cycle
			active <= 1'b0;
			count  <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Pulse exactly SWIPE_DELAY cycles after the trigger
	assign swipe = active && (count == CNT_W'(SWIPE_DELAY));

endmodule

// File: raster_reader.sv
// Raster reader
// Scans the selected image in raster order, one position per reader
// slot, and fetches visible pixels from the frame memory.
// A two-stage pipeline lines up de and the syncs with the returned
// pixel, so the outputs of a position appear two cycles after its fetch

module raster_reader #(
	parameter int H_ACTIVE = 16,
	parameter int H_TOTAL  = 20,
	parameter int V_ACTIVE = 8,
	parameter int V_TOTAL  = 10
) (
	input  logic                     CLOCK_33,
	input  logic                     iRSTN,
	input  logic                     rd_slot,
	input  slideshow_pkg::mem_addr_t base_addr,
	input  slideshow_pkg::pixel_t    rd_data,
	output slideshow_pkg::mem_req_t  rd_req,
	output logic                     frame_end,
	output slideshow_pkg::pixel_t    rgb,
	output logic                     de,
	output logic                     hsync_n,
	output logic                     vsync_n
);

	import slideshow_pkg::*;

	localparam int X_W = $clog2(H_TOTAL);
	localparam int Y_W = $clog2(V_TOTAL);

	scan_state_t    state;
	logic [X_W-1:0] x_pos;
	logic [X_W-1:0] x_next;
	logic [Y_W-1:0] y_pos;
	logic [Y_W-1:0] y_next;
	logic           step;
	logic           line_last;
	logic           frame_last;
	mem_addr_t      pix_idx;

	// First pipeline stage
	logic s1_valid;
	logic s1_de;
	logic s1_hs_n;
	logic s1_vs_n;

	// One scan position per reader slot once running
	assign step       = rd_slot && (state != SCAN_IDLE);
	assign line_last  = (x_pos == X_W'(H_TOTAL - 1));
	assign frame_last = line_last && (y_pos == Y_W'(V_TOTAL - 1));
	assign frame_end  = step && frame_last;

	// Next scan position
	always_comb begin
		x_next = x_pos + 1'b1;
		y_next = y_pos;
		if (line_last) begin
			x_next = '0;
			if (frame_last) begin
				y_next = '0;
			end else begin
				y_next = y_pos + 1'b1;
			end
		end
	end

	// ==============================
	// Fetch
	// ==============================

	// Index of the pixel inside its image
	assign pix_idx = mem_addr_t'(y_pos) * mem_addr_t'(H_ACTIVE) + mem_addr_t'(x_pos);

	// Only visible positions read the memory
	always_comb begin
		rd_req.valid = step && (state == SCAN_ACTIVE);
		rd_req.addr  = base_addr + pix_idx;
		rd_req.data  = '0;
	end

	// ==============================
	// Scan FSM
	// ==============================
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			state <= SCAN_IDLE;
			x_pos <= '0;
			y_pos <= '0;
		end else if (rd_slot) begin
			case (state)
				// First slot starts the scan at 0,0
				SCAN_IDLE: begin
					state <= SCAN_ACTIVE;
				end
				default: begin
					x_pos <= x_next;
					y_pos <= y_next;
					if ((x_next < H_ACTIVE) && (y_next < V_ACTIVE)) begin
						state <= SCAN_ACTIVE;
					end else begin
						state <= SCAN_BLANK;
					end
				end
			endcase
		end
	end

	// ==============================
	// Output pipeline
	// ==============================
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			s1_valid <= 1'b0;
			s1_de    <= 1'b0;
			s1_hs_n  <= 1'b1;
			s1_vs_n  <= 1'b1;
			de       <= 1'b0;
			hsync_n  <= 1'b1;
			vsync_n  <= 1'b1;
		end else begin
			// Stage 1 with the memory access
			s1_valid <= step;
			if (step) begin
				s1_de   <= (state == SCAN_ACTIVE);
				s1_hs_n <= !line_last;
				s1_vs_n <= (y_pos != Y_W'(V_TOTAL - 1));
			end
			// Stage 2 meets the read data
			if (s1_valid) begin
				de      <= s1_de;
				hsync_n <= s1_hs_n;
				vsync_n <= s1_vs_n;
			end
		end
	end

	// Pixel out, black in blanking
	always_ff @(posedge CLOCK_33) begin
		if (s1_valid) begin
			rgb <= s1_de ? rd_data : '0;
		end
	end

endmodule

// File: frame_mem.sv
// Frame memory
// Single-port on-chip memory holding four images back to back.
// Writes on mem_we, otherwise a valid request reads and the data
// appears one cycle later; it holds until the next read

module frame_mem (
	input  logic                    CLOCK_33,
	input  slideshow_pkg::mem_req_t mem_req,
	input  logic                    mem_we,
	output slideshow_pkg::pixel_t   rd_data
);

	import slideshow_pkg::*;

	// Every address of the memory is backed
	localparam int DEPTH = 2 ** $bits(mem_addr_t);

	pixel_t mem [0:DEPTH-1];

	// ==============================
	// Port
	// ==============================
	always_ff @(posedge CLOCK_33) begin
		if (mem_we) begin
			mem[mem_req.addr] <= mem_req.data;
		end else if (mem_req.valid) begin
			// Registered read
			rd_data <= mem[mem_req.addr];
		end
	end

endmodule

// File: mem_arbiter.sv
// Frame memory arbiter
// Fixed time slots, alternating every cycle after reset.
// Phase 0 belongs to the display reader, phase 1 to the pixel writer.
// No back-pressure: the writer holds its request until its slot
// and the reader only issues in its own slot

module mem_arbiter (
	input  logic                    CLOCK_33,
	input  logic                    iRSTN,
	input  slideshow_pkg::mem_req_t wr_req,
	input  slideshow_pkg::mem_req_t rd_req,
	output logic                    wr_slot,
	output logic                    rd_slot,
	output slideshow_pkg::mem_req_t mem_req,
	output logic                    mem_we
);

	// Slot owner, 0 reader, 1 writer
	logic phase;

	// ==============================
	// Slot counter
	// ==============================
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			// Reader owns the first cycle
			phase <= 1'b0;
		end else begin
			phase <= !phase;
		end
	end

	assign rd_slot = !phase;
	assign wr_slot = phase;

	// ==============================
	// Request mux
	// ==============================
	always_comb begin
		if (phase) begin
			mem_req = wr_req;
			// Only a pending pixel writes
			mem_we  = wr_req.valid;
		end else begin
			mem_req = rd_req;
			// Reader never writes
			mem_we  = 1'b0;
		end
	end

endmodule

// File: pixel_writer.sv
// Pixel writer
// Counts incoming pixel strobes and turns each accepted pixel into
// a write request at the next sequential frame memory address.
// The request is held until the arbiter grants the writer slot.
// Also drives the loading flag, which drops a settle time after
// the last image is complete

module pixel_writer #(
	parameter int PIXELS_PER_IMG = 128,
	parameter int LOAD_SETTLE    = 50
) (
	input  logic                    CLOCK_33,
	input  logic                    iRSTN,
	input  logic                    pixel_stb,
	input  slideshow_pkg::pixel_t   pixel_in,
	input  logic [2:0]              img_num,
	input  logic                    wr_slot,
	output slideshow_pkg::mem_req_t wr_req,
	output logic                    load_done,
	output logic                    loading
);

	import slideshow_pkg::*;

	// Counter spans a full memory plus one
	localparam int CNT_W    = $clog2(4 * PIXELS_PER_IMG + 1);
	localparam int SETTLE_W = $clog2(LOAD_SETTLE + 1);

	logic [CNT_W-1:0]    pix_cnt;
	logic [CNT_W-1:0]    pix_total;
	logic                pix_accept;
	logic [SETTLE_W-1:0] settle_cnt;

	// Pending write
	logic      req_valid;
	mem_addr_t req_addr;
	pixel_t    req_data;

	// Pixels in the whole slideshow
	assign pix_total  = CNT_W'(img_num) * CNT_W'(PIXELS_PER_IMG);
	// Strobes past the last image are dropped
	assign pix_accept = pixel_stb && (pix_cnt < pix_total);
	// All images received
	assign load_done  = (img_num != 3'd0) && (pix_cnt == pix_total);

	// ==============================
	// Pixel counter and request
	// ==============================
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			pix_cnt   <= '0;
			req_valid <= 1'b0;
		end else begin
			if (pix_accept) begin
				pix_cnt   <= pix_cnt + 1'b1;
				req_valid <= 1'b1;
			end else if (wr_slot) begin
				// Memory takes the pixel in this slot
				req_valid <= 1'b0;
			end
		end
	end

	// Address and data of the pending pixel
	always_ff @(posedge CLOCK_33) begin
		if (pix_accept) begin
			req_addr <= mem_addr_t'(pix_cnt);
			req_data <= pixel_in;
		end
	end

	assign wr_req = '{valid: req_valid, addr: req_addr, data: req_data};

	// ==============================
	// Loading flag
	// ==============================
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			loading    <= 1'b0;
			settle_cnt <= '0;
		end else begin
			if (pix_accept) begin
				// Up with the first pixel
				loading <= 1'b1;
			end else if (load_done && loading) begin
				// Settle count runs from the cycle load_done rises
				if (settle_cnt == SETTLE_W'(LOAD_SETTLE - 1)) begin
					loading <= 1'b0;
				end else begin
					settle_cnt <= settle_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: slideshow_pkg.sv
// Slideshow frame-buffer shared types
// Pixel, frame memory address and memory request formats,
// touch gesture codes and the raster scan states

package slideshow_pkg;

	// ==============================
	// Pixel and memory types
	// ==============================

	// One color channel
	typedef logic [7:0] color_t;

	// 24-bit pixel, red in the upper byte as sent by the loader
	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
	} pixel_t;

	// Frame memory address, room for four 128-pixel images
	typedef logic [8:0] mem_addr_t;

	// One memory request
	// Data only meaningful for writes
	typedef struct packed {
		logic      valid;
		mem_addr_t addr;
		pixel_t    data;
	} mem_req_t;

	// Index of one image in the slideshow
	typedef logic [1:0] img_idx_t;

	// ==============================
	// Touch gestures
	// ==============================

	// Raw gesture code from the touch panel
	typedef logic [7:0] gesture_t;

	// Slide towards the east edge
	localparam gesture_t GEST_EAST = 8'h14;
	// Slide towards the west edge
	localparam gesture_t GEST_WEST = 8'h1C;

	// Raster scan states
	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_ACTIVE,
		SCAN_BLANK
	} scan_state_t;

endpackage
